// ==== traffic_defs.svh ====
`ifndef TRAFFIC_DEFS_SVH
`define TRAFFIC_DEFS_SVH

// ==============================
// Intersection constants
// ==============================

// Clock cycles per displayed second
// Small for simulation, any value of 2 or more works
`define TICKS_PER_SEC 8

// Width of every seconds field (durations and countdown)
`define SEC_W 8

// Approaches at the intersection
`define NUM_DIRS 4

`endif

// ==== traffic_pkg.sv ====
`include "traffic_defs.svh"

package traffic_pkg;

    // ==============================
    // Directions and phases
    // ==============================

    // Approach index, also the bit index into every lamp vector
    typedef enum logic [$clog2(`NUM_DIRS)-1:0] {
        NORTH = 2'd0,
        EAST  = 2'd1,
        SOUTH = 2'd2,
        WEST  = 2'd3
    } dir_t;

    // Phase kinds of the automatic cycle
    // TRANSITION only follows a return from manual mode
    typedef enum logic [1:0] {
        GREEN      = 2'd0,
        YELLOW     = 2'd1,
        ALL_RED    = 2'd2,
        TRANSITION = 2'd3
    } phase_t;

    // ==============================
    // Lamps and timing
    // ==============================

    // One bit per approach in each colour, indexed by dir_t
    // At most one colour lit per approach
    typedef struct packed {
        logic [`NUM_DIRS-1:0] red;
        logic [`NUM_DIRS-1:0] yellow;
        logic [`NUM_DIRS-1:0] green;
    } lamp_set_t;

    // Phase durations in seconds, zero behaves as one
    typedef struct packed {
        logic [`SEC_W-1:0] green_sec;
        logic [`SEC_W-1:0] yellow_sec;
        logic [`SEC_W-1:0] red_hold_sec;
    } timing_cfg_t;

    // ==============================
    // Switch word
    // ==============================

    // Sequential view, one switch per approach
    typedef struct packed {
        logic [9:0] spare;
        logic       west;
        logic       south;
        logic       east;
        logic       north;
        logic       parallel;
        logic       manual;
    } switch_seq_t;

    // Parallel view, bits 2 and 3 pick an opposing pair
    typedef struct packed {
        logic [11:0] spare;
        logic        ew_pair;
        logic        ns_pair;
        logic        parallel;
        logic        manual;
    } switch_par_t;

    // Same 16 switches, decoded per selection style
    typedef union packed {
        switch_seq_t seq;
        switch_par_t par;
    } switch_word_u;

    // ==============================
    // Status
    // ==============================

    typedef struct packed {
        logic [`SEC_W-1:0] countdown;
        dir_t              direction;
        logic              transition;
        logic              show_countdown;
    } status_t;

endpackage

// ==== phase_timer.sv ====
`timescale 1ns/1ps
`include "traffic_defs.svh"

module phase_timer (
    input  logic              clk,
    input  logic              rst,
    input  logic              restart,
    input  logic [`SEC_W-1:0] limit_sec,
    output logic              done,
    output logic [`SEC_W-1:0] countdown
);

    // ==============================
    // Prescaler constants
    // ==============================

    localparam int SUB_W = $clog2(`TICKS_PER_SEC);
    localparam logic [SUB_W-1:0] SUB_LAST = SUB_W'(`TICKS_PER_SEC - 1);

    // Cycle within the current second
    logic [SUB_W-1:0]  sub_cnt;
    // Whole seconds completed in this phase
    logic [`SEC_W-1:0] sec_cnt;

    logic [`SEC_W-1:0] eff_limit;
    logic              sec_end;
    logic              phase_end;

    // ==============================
    // End of phase
    // ==============================

    // Zero duration still runs one second
    assign eff_limit = (limit_sec == '0) ? `SEC_W'(1) : limit_sec;

    // Last cycle of a second
    assign sec_end = (sub_cnt == SUB_LAST);

    // Last cycle of the last second, live limit so changes apply at once
    assign phase_end = sec_end && (sec_cnt >= eff_limit - `SEC_W'(1));

    // A restart swallows the pulse
    assign done = phase_end && !restart;

    // Seconds left, floored at zero when the limit drops below the count
    assign countdown = (limit_sec > sec_cnt) ? (limit_sec - sec_cnt) : '0;

    // ==============================
    // Counters
    // ==============================

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sub_cnt <= '0;
            sec_cnt <= '0;
        end else if (restart || phase_end) begin
            // New phase starts from zero
            sub_cnt <= '0;
            sec_cnt <= '0;
        end else if (sec_end) begin
            sub_cnt <= '0;
            sec_cnt <= sec_cnt + `SEC_W'(1);
        end else begin
            sub_cnt <= sub_cnt + SUB_W'(1);
        end
    end

endmodule

// ==== auto_sequencer.sv ====
`timescale 1ns/1ps
`include "traffic_defs.svh"

module auto_sequencer (
    input  logic                       clk,
    input  logic                       rst,
    input  traffic_pkg::switch_word_u  switches,
    input  traffic_pkg::timing_cfg_t   timing,
    input  logic [`NUM_DIRS-1:0]       manual_green,
    output traffic_pkg::lamp_set_t     auto_lamps,
    output traffic_pkg::dir_t          auto_dir,
    output logic                       auto_owns,
    output logic                       in_transition,
    output logic [`SEC_W-1:0]          countdown
);

    // Phase state
    traffic_pkg::dir_t   cur_dir;
    traffic_pkg::phase_t cur_phase;
    traffic_pkg::dir_t   nxt_dir;
    traffic_pkg::phase_t nxt_phase;

    // Mode tracking
    logic manual;
    logic manual_q;
    logic pending;
    logic rise;
    logic fall;
    logic hold;

    // Green lamps of manual mode, shown as yellow in TRANSITION
    logic [`NUM_DIRS-1:0] snapshot;

    // Timer handshake
    logic [`SEC_W-1:0] limit_sec;
    logic              restart;
    logic              done;

    // ==============================
    // Mode edges
    // ==============================

    assign manual = switches.seq.manual;
    assign rise   = manual && !manual_q;
    assign fall   = !manual && manual_q;

    // Pure manual, nothing left of the automatic cycle
    assign hold = manual && !pending && !rise;

    // Timer starts over on TRANSITION entry and while held
    assign restart = fall || hold;

    // Duration of the running phase
    always_comb begin
        case (cur_phase)
            traffic_pkg::GREEN:   limit_sec = timing.green_sec;
            traffic_pkg::ALL_RED: limit_sec = timing.red_hold_sec;
            // Yellow and TRANSITION share the yellow time
            default:              limit_sec = timing.yellow_sec;
        endcase
    end

    phase_timer u_timer (
        .clk       (clk),
        .rst       (rst),
        .restart   (restart),
        .limit_sec (limit_sec),
        .done      (done),
        .countdown (countdown)
    );

    // ==============================
    // Next phase
    // ==============================

    always_comb begin
        nxt_dir   = cur_dir;
        nxt_phase = cur_phase;
        case (cur_phase)
            traffic_pkg::GREEN:  nxt_phase = traffic_pkg::YELLOW;
            traffic_pkg::YELLOW: nxt_phase = traffic_pkg::ALL_RED;
            traffic_pkg::ALL_RED: begin
                // N -> E -> S -> W -> N
                nxt_phase = traffic_pkg::GREEN;
                nxt_dir   = traffic_pkg::dir_t'(cur_dir + 1'b1);
            end
            default: begin
                // TRANSITION restarts the cycle at North
                nxt_phase = traffic_pkg::GREEN;
                nxt_dir   = traffic_pkg::NORTH;
            end
        endcase
    end

    // ==============================
    // State registers
    // ==============================

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cur_dir   <= traffic_pkg::NORTH;
            cur_phase <= traffic_pkg::GREEN;
            manual_q  <= 1'b0;
            pending   <= 1'b0;
        end else begin
            manual_q <= manual;
            if (!manual) begin
                if (fall) begin
                    // Back to automatic through a yellow phase
                    cur_phase <= traffic_pkg::TRANSITION;
                    cur_dir   <= traffic_pkg::NORTH;
                end else if (done) begin
                    cur_phase <= nxt_phase;
                    cur_dir   <= nxt_dir;
                end
            end else if (pending || rise) begin
                // Finish the automatic cycle up to the next all-red
                pending <= 1'b1;
                if (done) begin
                    cur_phase <= nxt_phase;
                    cur_dir   <= nxt_dir;
                    if (nxt_phase == traffic_pkg::ALL_RED) begin
                        pending <= 1'b0;
                    end
                end
            end else begin
                // Parked at North green while manual owns the lamps
                cur_phase <= traffic_pkg::GREEN;
                cur_dir   <= traffic_pkg::NORTH;
            end
        end
    end

    // Captured on the manual to automatic edge
    always_ff @(posedge clk) begin
        if (fall) begin
            snapshot <= manual_green;
        end
    end

    // ==============================
    // Lamp decoding
    // ==============================

    always_comb begin
        auto_lamps.red    = '1;
        auto_lamps.yellow = '0;
        auto_lamps.green  = '0;
        case (cur_phase)
            traffic_pkg::GREEN: begin
                auto_lamps.red[cur_dir]   = 1'b0;
                auto_lamps.green[cur_dir] = 1'b1;
            end
            traffic_pkg::YELLOW: begin
                auto_lamps.red[cur_dir]    = 1'b0;
                auto_lamps.yellow[cur_dir] = 1'b1;
            end
            traffic_pkg::TRANSITION: begin
                // Former manual greens go yellow, the rest stay red
                auto_lamps.yellow = snapshot;
                auto_lamps.red    = ~snapshot;
            end
            default: ;
        endcase
    end

    assign auto_dir      = cur_dir;
    assign in_transition = (cur_phase == traffic_pkg::TRANSITION);

    // Automatic lamps stay on until manual takes over at all-red
    assign auto_owns = !manual || pending;

endmodule

// ==== manual_selector.sv ====
`timescale 1ns/1ps
`include "traffic_defs.svh"

module manual_selector (
    input  traffic_pkg::switch_word_u switches,
    output traffic_pkg::lamp_set_t    manual_lamps,
    output traffic_pkg::dir_t         manual_dir
);

    logic [`NUM_DIRS-1:0] green;

    // ==============================
    // Switch decoding
    // ==============================

    always_comb begin
        green      = '0;
        manual_dir = traffic_pkg::NORTH;
        if (!switches.seq.parallel) begin
            // Sequential, first set switch wins
            if (switches.seq.north) begin
                green[traffic_pkg::NORTH] = 1'b1;
            end else if (switches.seq.east) begin
                green[traffic_pkg::EAST] = 1'b1;
                manual_dir               = traffic_pkg::EAST;
            end else if (switches.seq.south) begin
                green[traffic_pkg::SOUTH] = 1'b1;
                manual_dir                = traffic_pkg::SOUTH;
            end else if (switches.seq.west) begin
                green[traffic_pkg::WEST] = 1'b1;
                manual_dir               = traffic_pkg::WEST;
            end
        end else begin
            // Parallel, exactly one pair or nothing
            if (switches.par.ns_pair && !switches.par.ew_pair) begin
                green[traffic_pkg::NORTH] = 1'b1;
                green[traffic_pkg::SOUTH] = 1'b1;
            end else if (switches.par.ew_pair && !switches.par.ns_pair) begin
                green[traffic_pkg::EAST] = 1'b1;
                green[traffic_pkg::WEST] = 1'b1;
            end
            // Direction by switch priority, even when lamps are all red
            if (!switches.par.ns_pair && switches.par.ew_pair) begin
                manual_dir = traffic_pkg::EAST;
            end
        end
    end

    // No yellow in manual, everything not green is red
    assign manual_lamps.green  = green;
    assign manual_lamps.yellow = '0;
    assign manual_lamps.red    = ~green;

endmodule

// ==== lamp_arbiter.sv ====
`timescale 1ns/1ps
`include "traffic_defs.svh"

module lamp_arbiter (
    input  traffic_pkg::lamp_set_t auto_lamps,
    input  traffic_pkg::dir_t      auto_dir,
    input  logic                   auto_owns,
    input  logic                   in_transition,
    input  logic [`SEC_W-1:0]      countdown,
    input  traffic_pkg::lamp_set_t manual_lamps,
    input  traffic_pkg::dir_t      manual_dir,
    output traffic_pkg::lamp_set_t lamps,
    output traffic_pkg::status_t   status
);

    // ==============================
    // Lamp ownership
    // ==============================

    // Sequencer owns the lamps in automatic mode and while manual is pending
    assign lamps            = auto_owns ? auto_lamps : manual_lamps;
    assign status.direction = auto_owns ? auto_dir : manual_dir;

    // ==============================
    // Status word
    // ==============================

    // Countdown value always from the timer
    assign status.countdown = countdown;

    // Yellow hand-back from manual
    assign status.transition = in_transition;

    // Hidden in pure manual only
    assign status.show_countdown = auto_owns;

endmodule

// ==== traffic_light_top.sv ====
`timescale 1ns/1ps
`include "traffic_defs.svh"

module traffic_light_top (
    input  logic                      clk,
    input  logic                      rst,
    input  traffic_pkg::switch_word_u switches,
    input  traffic_pkg::timing_cfg_t  timing,
    output traffic_pkg::lamp_set_t    lamps,
    output traffic_pkg::status_t      status
);

    // Automatic side
    traffic_pkg::lamp_set_t auto_lamps;
    traffic_pkg::dir_t      auto_dir;
    logic                   auto_owns;
    logic                   in_transition;
    logic [`SEC_W-1:0]      countdown;

    // Manual side
    traffic_pkg::lamp_set_t manual_lamps;
    traffic_pkg::dir_t      manual_dir;

    // ==============================
    // Sequencer and selector
    // ==============================

    // Manual greens feed the TRANSITION snapshot
    auto_sequencer u_seq (
        .clk           (clk),
        .rst           (rst),
        .switches      (switches),
        .timing        (timing),
        .manual_green  (manual_lamps.green),
        .auto_lamps    (auto_lamps),
        .auto_dir      (auto_dir),
        .auto_owns     (auto_owns),
        .in_transition (in_transition),
        .countdown     (countdown)
    );

    manual_selector u_sel (
        .switches     (switches),
        .manual_lamps (manual_lamps),
        .manual_dir   (manual_dir)
    );

    // ==============================
    // Output select
    // ==============================

    lamp_arbiter u_arb (
        .auto_lamps    (auto_lamps),
        .auto_dir      (auto_dir),
        .auto_owns     (auto_owns),
        .in_transition (in_transition),
        .countdown     (countdown),
        .manual_lamps  (manual_lamps),
        .manual_dir    (manual_dir),
        .lamps         (lamps),
        .status        (status)
    );

endmodule

// ==== tb_traffic_model.svh ====
`ifndef TB_TRAFFIC_MODEL_SVH
`define TB_TRAFFIC_MODEL_SVH

// ==============================
// Reference model state
// ==============================

typedef struct packed {
    traffic_pkg::dir_t    dir;
    traffic_pkg::phase_t  phase;
    logic [15:0]          sub;
    logic [`SEC_W-1:0]    sec;
    logic                 manual_q;
    logic                 pending;
    logic [`NUM_DIRS-1:0] snapshot;
} model_state_t;

// LFSR register, seeded by the testbench top
logic [31:0] lfsr_state;

// State right after reset, North green with nothing pending
function automatic model_state_t reset_model();
    model_state_t r;
    r = '0;
    r.dir   = traffic_pkg::NORTH;
    r.phase = traffic_pkg::GREEN;
    return r;
endfunction

// Manual greens and direction from the switch word
function automatic void manual_view(
    input  traffic_pkg::switch_word_u sw,
    output logic [`NUM_DIRS-1:0]      grn,
    output traffic_pkg::dir_t         dir
);
    logic [`NUM_DIRS-1:0] req;
    grn = '0;
    dir = traffic_pkg::NORTH;
    req = {sw.seq.west, sw.seq.south, sw.seq.east, sw.seq.north};
    if (sw.seq.parallel) begin
        case ({sw.par.ew_pair, sw.par.ns_pair})
            2'b01: grn = 4'b0101;
            2'b10: begin
                grn = 4'b1010;
                dir = traffic_pkg::EAST;
            end
            default: ;
        endcase
    end else begin
        // Scan from west down so north ends up winning
        for (int d = `NUM_DIRS - 1; d >= 0; d--) begin
            if (req[d]) begin
                grn = 4'b0001 << d;
                dir = traffic_pkg::dir_t'(d);
            end
        end
    end
endfunction

// One clock of the intersection, outputs from the current state
function automatic model_state_t step_model(
    input  model_state_t              s,
    input  traffic_pkg::switch_word_u sw,
    input  traffic_pkg::timing_cfg_t  t,
    output traffic_pkg::lamp_set_t    lamps_exp,
    output traffic_pkg::status_t      status_exp
);
    model_state_t           n;
    traffic_pkg::lamp_set_t auto_set;
    traffic_pkg::lamp_set_t man_set;
    traffic_pkg::dir_t      man_dir;
    traffic_pkg::phase_t    adv_phase;
    traffic_pkg::dir_t      adv_dir;
    logic [`NUM_DIRS-1:0]   man_grn;
    logic [`SEC_W-1:0]      limit;
    logic [`SEC_W:0]        need;
    logic manual, rise, fall, hold, restart;
    logic owns, sec_end, last, done;

    manual  = sw.seq.manual;
    rise    = manual && !s.manual_q;
    fall    = !manual && s.manual_q;
    hold    = manual && !s.pending && !rise;
    restart = fall || hold;
    owns    = !manual || s.pending;

    // Phase length, zero seconds runs as one
    case (s.phase)
        traffic_pkg::GREEN:   limit = t.green_sec;
        traffic_pkg::ALL_RED: limit = t.red_hold_sec;
        default:              limit = t.yellow_sec;
    endcase
    need    = (limit == '0) ? 9'd1 : {1'b0, limit};
    sec_end = (s.sub == `TICKS_PER_SEC - 1);
    last    = sec_end && (({1'b0, s.sec} + 9'd1) >= need);
    done    = last && !restart;

    // Where the cycle goes on done
    adv_dir = s.dir;
    case (s.phase)
        traffic_pkg::GREEN:  adv_phase = traffic_pkg::YELLOW;
        traffic_pkg::YELLOW: adv_phase = traffic_pkg::ALL_RED;
        traffic_pkg::ALL_RED: begin
            adv_phase = traffic_pkg::GREEN;
            adv_dir   = traffic_pkg::dir_t'((int'(s.dir) + 1) % `NUM_DIRS);
        end
        default: begin
            adv_phase = traffic_pkg::GREEN;
            adv_dir   = traffic_pkg::NORTH;
        end
    endcase

    // Expected lamps on both sides
    manual_view(sw, man_grn, man_dir);
    man_set.green  = man_grn;
    man_set.yellow = '0;
    man_set.red    = ~man_grn;
    auto_set.green  = '0;
    auto_set.yellow = '0;
    case (s.phase)
        traffic_pkg::GREEN:      auto_set.green  = 4'b0001 << s.dir;
        traffic_pkg::YELLOW:     auto_set.yellow = 4'b0001 << s.dir;
        traffic_pkg::TRANSITION: auto_set.yellow = s.snapshot;
        default: ;
    endcase
    auto_set.red = ~(auto_set.green | auto_set.yellow);

    lamps_exp                 = owns ? auto_set : man_set;
    status_exp.countdown      = (limit > s.sec) ? (limit - s.sec) : '0;
    status_exp.direction      = owns ? s.dir : man_dir;
    status_exp.transition     = (s.phase == traffic_pkg::TRANSITION);
    status_exp.show_countdown = owns;

    // Prescaler and seconds
    n = s;
    n.manual_q = manual;
    if (restart || last) begin
        n.sub = '0;
        n.sec = '0;
    end else if (sec_end) begin
        n.sub = '0;
        n.sec = s.sec + 1'b1;
    end else begin
        n.sub = s.sub + 1'b1;
    end

    // Mode handling
    if (!manual) begin
        if (fall) begin
            n.phase    = traffic_pkg::TRANSITION;
            n.dir      = traffic_pkg::NORTH;
            n.snapshot = man_grn;
        end else if (done) begin
            n.phase = adv_phase;
            n.dir   = adv_dir;
        end
    end else if (s.pending || rise) begin
        n.pending = 1'b1;
        if (done) begin
            n.phase = adv_phase;
            n.dir   = adv_dir;
            // Manual takes over once all-red is reached
            if (adv_phase == traffic_pkg::ALL_RED) begin
                n.pending = 1'b0;
            end
        end
    end else begin
        n.phase = traffic_pkg::GREEN;
        n.dir   = traffic_pkg::NORTH;
    end
    return n;
endfunction

// ==============================
// Random bits
// ==============================

// Taps 32, 22, 2, 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

task automatic take_bits(input int count, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < count; i++) begin
        lfsr_state = lfsr_next(lfsr_state);
        bits = {bits[30:0], lfsr_state[0]};
    end
endtask

// ==============================
// Compare tasks
// ==============================

task automatic check_lamps(input traffic_pkg::lamp_set_t got, input traffic_pkg::lamp_set_t exp);
    if (got !== exp) begin
        $display("MISMATCH lamps: got %h expected %h at %0t", got, exp, $time);
        $display("Simulation failed");
        $fatal(1);
    end
endtask

task automatic check_status(input traffic_pkg::status_t got, input traffic_pkg::status_t exp);
    if (got !== exp) begin
        $display("MISMATCH status: got %h expected %h at %0t", got, exp, $time);
        $display("Simulation failed");
        $fatal(1);
    end
endtask

`endif

// ==== tb_traffic.sv ====
`timescale 1ns/1ps
`include "traffic_defs.svh"

module tb_traffic;

    logic                      clk;
    logic                      rst;
    traffic_pkg::switch_word_u switches;
    traffic_pkg::timing_cfg_t  timing;
    traffic_pkg::lamp_set_t    lamps;
    traffic_pkg::status_t      status;

    `include "tb_traffic_model.svh"

    // Events a wait can look for
    localparam int EV_MANUAL_OWNS = 0;
    localparam int EV_TRANS_ON    = 1;
    localparam int EV_TRANS_OFF   = 2;
    localparam int EV_GREEN       = 3;
    localparam int TPS            = `TICKS_PER_SEC;

    model_state_t           model;
    traffic_pkg::lamp_set_t exp_lamps;
    traffic_pkg::status_t   exp_status;

    traffic_light_top DUT (
        .clk      (clk),
        .rst      (rst),
        .switches (switches),
        .timing   (timing),
        .lamps    (lamps),
        .status   (status)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ==============================
    // Model and compare
    // ==============================

    // Inputs and outputs both settled at mid-cycle
    always @(negedge clk) begin
        if (rst) begin
            model = reset_model();
        end else begin
            model = step_model(model, switches, timing, exp_lamps, exp_status);
            check_lamps(lamps, exp_lamps);
            check_status(status, exp_status);
        end
    end

    // New inputs just after the rising edge
    task automatic apply(input traffic_pkg::switch_word_u sw, input traffic_pkg::timing_cfg_t t);
        @(posedge clk);
        #2;
        switches = sw;
        timing   = t;
    endtask

    task automatic wait_for(input int kind, input int limit);
        int   n;
        logic hit;
        n   = 0;
        hit = 1'b0;
        while (!hit) begin
            @(negedge clk);
            case (kind)
                EV_MANUAL_OWNS: hit = !status.show_countdown;
                EV_TRANS_ON:    hit = status.transition;
                EV_TRANS_OFF:   hit = !status.transition;
                default:        hit = |lamps.green;
            endcase
            n++;
            if (!hit && n >= limit) begin
                $display("Timeout after %0d cycles waiting for event %0d", n, kind);
                $display("Simulation failed");
                $fatal(1);
            end
        end
    endtask

    // Manual until it owns the lamps, then back through one yellow phase
    task automatic leave_manual(input traffic_pkg::switch_word_u sw);
        apply(sw, timing);
        wait_for(EV_MANUAL_OWNS,
                 (int'(timing.green_sec) + int'(timing.yellow_sec)
                  + int'(timing.red_hold_sec) + 3) * TPS);
        repeat (4) @(posedge clk);
        sw.seq.manual = 1'b0;
        apply(sw, timing);
        wait_for(EV_TRANS_ON, 4);
        wait_for(EV_TRANS_OFF, (int'(timing.yellow_sec) + 2) * TPS);
        repeat (10) @(posedge clk);
    endtask

    // ==============================
    // Stimulus
    // ==============================

    initial begin
        logic [31:0]               r;
        logic [15:0]               seen;
        int                        tries;
        traffic_pkg::switch_word_u sw;
        traffic_pkg::timing_cfg_t  t;

        lfsr_state = 32'h389456af;
        rst        = 1'b1;
        switches   = '0;
        timing     = '{green_sec: 8'd2, yellow_sec: 8'd1, red_hold_sec: 8'd1};
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;

        // Two full automatic cycles and one more with zero yellow and hold
        repeat (2 * `NUM_DIRS * 4 * TPS) @(posedge clk);
        t = '{green_sec: 8'd2, yellow_sec: 8'd0, red_hold_sec: 8'd0};
        apply(switches, t);
        repeat (`NUM_DIRS * 4 * TPS) @(posedge clk);

        // Manual requested mid-green takes over at the next all-red
        t = '{green_sec: 8'd2, yellow_sec: 8'd1, red_hold_sec: 8'd1};
        apply(switches, t);
        wait_for(EV_GREEN, 5 * TPS);
        repeat (5) @(posedge clk);
        sw = '0;
        sw.seq.manual = 1'b1;
        sw.seq.east   = 1'b1;
        apply(sw, t);
        wait_for(EV_MANUAL_OWNS, 5 * TPS);
        repeat (10) @(posedge clk);

        // Sequential priority until all 16 combinations showed up
        seen  = '0;
        tries = 0;
        while (seen != 16'hffff) begin
            take_bits(14, r);
            sw = {r[13:4], r[3:0], 1'b0, 1'b1};
            seen[r[3:0]] = 1'b1;
            apply(sw, t);
            repeat (2) @(posedge clk);
            tries++;
            if (seen != 16'hffff && tries >= 400) begin
                $display("LFSR did not cover all switch combinations");
                $display("Simulation failed");
                $fatal(1);
            end
        end

        // Parallel pairs where both and neither stay all red
        for (int i = 0; i < 4; i++) begin
            take_bits(12, r);
            sw = {r[11:0], i[1:0], 1'b1, 1'b1};
            apply(sw, t);
            repeat (3) @(posedge clk);
        end

        // Hand-back from sequential and from parallel selection
        sw = '0;
        sw.seq.manual = 1'b1;
        sw.seq.east   = 1'b1;
        sw.seq.south  = 1'b1;
        leave_manual(sw);
        sw = '0;
        sw.par.manual   = 1'b1;
        sw.par.parallel = 1'b1;
        sw.par.ns_pair  = 1'b1;
        leave_manual(sw);

        // Random modes and switches and limits that often change mid-phase
        for (int c = 0; c < 4000; c++) begin
            sw = switches;
            t  = timing;
            take_bits(4, r);
            if (r[3:0] == 4'd0) begin
                sw.seq.manual = !sw.seq.manual;
            end
            take_bits(3, r);
            if (r[2:0] == 3'd0) begin
                take_bits(15, r);
                sw = {r[14:0], sw.seq.manual};
            end
            take_bits(6, r);
            if (r[5:0] == 6'd0) begin
                take_bits(6, r);
                t.green_sec    = r[1:0];
                t.yellow_sec   = r[3:2];
                t.red_hold_sec = r[5:4];
            end
            apply(sw, t);
        end

        repeat (5) @(posedge clk);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+.
traffic_pkg.sv
phase_timer.sv
auto_sequencer.sv
manual_selector.sv
lamp_arbiter.sv
traffic_light_top.sv
tb_traffic.sv
